//--- src.f
+incdir+design
+incdir+dv
design/rv_dec_pkg.sv
design/inst_class_decode.sv
design/alu_ctrl_decode.sv
design/flow_mem_decode.sv
design/imm_gen.sv
design/decode_stage.sv
dv/tb_decode_stage.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -f src.f \
    --top-module tb_decode_stage -o sim_decode
./obj_dir/sim_decode | tee sim.log

if grep -qx "test passed" sim.log; then
    echo "simulation result: pass"
    exit 0
fi
echo "simulation result: FAIL"
exit 1

//--- dv/decode_ref.svh
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// expected control word, one field per decoded output
typedef struct packed {
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    alu_op_t   alu_op;
    logic      src1_pc;
    alu_src2_t src2;
    logic      jump;
    logic      jump_pc_rel;
    br_cmp_t   br_cmp;
    logic      write_gpr;
    logic      mem_to_reg;
    logic      write_mem;
    mem_size_t mem_size;
    logic      halt;
    imm_t      imm;
} ctrl_word_t;

// alu op for the register and immediate alu forms
function automatic alu_op_t arith_alu_op(input funct3_t f3, input funct7_t f7,
                                         input logic is_reg);
    alu_op_t op;
    op = '0;
    case (f3)
        3'b000: begin
            if (!is_reg || f7 == 7'b0000000) begin
                op[`DEC_ALU_ADD] = 1'b1;
            end else if (f7 == `DEC_F7_ALT) begin
                op[`DEC_ALU_SUB] = 1'b1;
            end
        end
        3'b001:  op[`DEC_ALU_SLL]  = 1'b1;
        3'b010:  op[`DEC_ALU_SLT]  = 1'b1;
        3'b011:  op[`DEC_ALU_SLTU] = 1'b1;
        3'b100:  op[`DEC_ALU_XOR]  = 1'b1;
        3'b101: begin
            // instruction bit 30
            if (f7[5]) begin
                op[`DEC_ALU_SRA] = 1'b1;
            end else begin
                op[`DEC_ALU_SRL] = 1'b1;
            end
        end
        3'b110:  op[`DEC_ALU_OR]   = 1'b1;
        default: op[`DEC_ALU_AND]  = 1'b1;
    endcase
    return op;
endfunction

// access size, unsigned variants only for loads
function automatic mem_size_t mem_size_of(input funct3_t f3, input logic is_load);
    mem_size_t sz;
    sz = '0;
    case (f3)
        3'b000: sz[`DEC_MEM_BYTE] = 1'b1;
        3'b001: sz[`DEC_MEM_HALF] = 1'b1;
        3'b010: sz[`DEC_MEM_WORD] = 1'b1;
        3'b100: sz[`DEC_MEM_BYTE_U] = is_load;
        3'b101: sz[`DEC_MEM_HALF_U] = is_load;
        default: sz = '0;
    endcase
    return sz;
endfunction

function automatic ctrl_word_t decode_ref(input inst_t inst);
    ctrl_word_t c;
    funct3_t    f3;
    funct7_t    f7;
    logic       ebreak;
    c  = '0;
    f3 = inst[14:12];
    f7 = inst[31:25];
    c.rd  = inst[11:7];
    c.rs1 = inst[19:15];
    c.rs2 = inst[24:20];
    ebreak = (inst[6:0] == `DEC_OPC_SYSTEM) && (f3 == 3'b000)
          && (inst[31:20] == `DEC_EBREAK_IMM);
    c.write_gpr = 1'b1;

    case (inst[6:0])
        `DEC_OPC_OP_IMM: begin
            c.alu_op = arith_alu_op(f3, f7, 1'b0);
            c.src2[`DEC_SRC2_IMM] = 1'b1;
            c.imm = {{20{inst[31]}}, inst[31:20]};
        end
        `DEC_OPC_OP: begin
            c.alu_op = arith_alu_op(f3, f7, 1'b1);
            c.src2[`DEC_SRC2_RS2] = 1'b1;
        end
        `DEC_OPC_LOAD: begin
            c.alu_op[`DEC_ALU_ADD] = 1'b1;
            c.src2[`DEC_SRC2_IMM] = 1'b1;
            c.mem_to_reg = 1'b1;
            c.mem_size = mem_size_of(f3, 1'b1);
            c.imm = {{20{inst[31]}}, inst[31:20]};
        end
        `DEC_OPC_STORE: begin
            c.alu_op[`DEC_ALU_ADD] = 1'b1;
            c.src2[`DEC_SRC2_IMM] = 1'b1;
            c.write_mem = 1'b1;
            c.write_gpr = 1'b0;
            c.mem_size = mem_size_of(f3, 1'b0);
            c.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        end
        `DEC_OPC_BRANCH: begin
            c.alu_op[`DEC_ALU_SLT]  = (f3 == 3'b000) || (f3 == 3'b001)
                                   || (f3 == 3'b100) || (f3 == 3'b101);
            c.alu_op[`DEC_ALU_SLTU] = (f3 == 3'b110) || (f3 == 3'b111);
            c.br_cmp[`DEC_CMP_EQ]  = (f3 == 3'b000);
            c.br_cmp[`DEC_CMP_NEQ] = (f3 == 3'b001);
            c.br_cmp[`DEC_CMP_LT]  = (f3 == 3'b100) || (f3 == 3'b110);
            c.br_cmp[`DEC_CMP_GE]  = (f3 == 3'b101) || (f3 == 3'b111);
            c.src2[`DEC_SRC2_RS2] = 1'b1;
            c.jump = 1'b1;
            c.jump_pc_rel = 1'b1;
            c.write_gpr = 1'b0;
            c.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        end
        `DEC_OPC_JAL: begin
            c.alu_op[`DEC_ALU_ADD] = 1'b1;
            c.src1_pc = 1'b1;
            c.src2[`DEC_SRC2_FOUR] = 1'b1;
            c.jump = 1'b1;
            c.jump_pc_rel = 1'b1;
            c.imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        `DEC_OPC_JALR: begin
            c.alu_op[`DEC_ALU_ADD] = 1'b1;
            c.src1_pc = 1'b1;
            c.src2[`DEC_SRC2_FOUR] = 1'b1;
            c.jump = 1'b1;
            c.imm = {{20{inst[31]}}, inst[31:20]};
        end
        `DEC_OPC_LUI: begin
            c.alu_op[`DEC_ALU_EXPLICIT] = 1'b1;
            c.src2[`DEC_SRC2_IMM] = 1'b1;
            c.imm = {inst[31:12], 12'h000};
        end
        `DEC_OPC_AUIPC: begin
            c.alu_op[`DEC_ALU_ADD] = 1'b1;
            c.src1_pc = 1'b1;
            c.src2[`DEC_SRC2_IMM] = 1'b1;
            c.imm = {inst[31:12], 12'h000};
        end
        `DEC_OPC_SYSTEM: begin
            c.halt = ebreak;
            c.write_gpr = !ebreak;
            c.imm = {{20{inst[31]}}, inst[31:20]};
        end
        // unknown opcode, no class at all
        default: c.imm = '0;
    endcase
    return c;
endfunction

`endif

//--- dv/tb_decode_stage.sv
`timescale 1ns/1ps
`include "rv_dec_cfg.svh"

module tb_decode_stage;

    import rv_dec_pkg::*;

    `include "decode_ref.svh"

    localparam int N_INST       = 400;
    localparam int RESET_CYCLES = 16;
    // about five cycles per instruction covers the random stalls
    localparam int CYCLE_LIMIT  = RESET_CYCLES + N_INST * 5;
    // window where both sides stay ready
    localparam int BURST_FIRST  = 200;
    localparam int BURST_LAST   = 260;

    logic      clk_i;
    logic      rst_n_i;
    logic      in_valid_i;
    logic      in_ready_o;
    inst_t     inst_i;
    logic      out_valid_o;
    logic      out_ready_i;
    reg_addr_t rd_o;
    reg_addr_t rs1_o;
    reg_addr_t rs2_o;
    alu_op_t   alu_op_o;
    logic      src1_pc_o;
    alu_src2_t src2_o;
    logic      jump_o;
    logic      jump_pc_rel_o;
    br_cmp_t   br_cmp_o;
    logic      write_gpr_o;
    logic      mem_to_reg_o;
    logic      write_mem_o;
    mem_size_t mem_size_o;
    logic      halt_o;
    imm_t      imm_o;

    integer     seed = 32'hd22c;
    inst_t      inst_q[$];
    int         n_sent;
    int         n_recv;
    int         n_fail;
    int         n_err;
    int         cycles = 0;
    logic       in_fire;
    logic       prev_stall;
    logic       burst;
    logic       mon_on;
    ctrl_word_t prev_word;

    decode_stage dut_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .in_valid_i    (in_valid_i),
        .in_ready_o    (in_ready_o),
        .inst_i        (inst_i),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .rd_o          (rd_o),
        .rs1_o         (rs1_o),
        .rs2_o         (rs2_o),
        .alu_op_o      (alu_op_o),
        .src1_pc_o     (src1_pc_o),
        .src2_o        (src2_o),
        .jump_o        (jump_o),
        .jump_pc_rel_o (jump_pc_rel_o),
        .br_cmp_o      (br_cmp_o),
        .write_gpr_o   (write_gpr_o),
        .mem_to_reg_o  (mem_to_reg_o),
        .write_mem_o   (write_mem_o),
        .mem_size_o    (mem_size_o),
        .halt_o        (halt_o),
        .imm_o         (imm_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // ==================================================================
    // helpers
    // ==================================================================
    task automatic check_val(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        if (got !== exp) begin
            $display("Fail %0t: %s got %0h expected %0h", $time, name, got, exp);
            n_fail++;
        end
    endtask

    function automatic inst_t gen_inst();
        inst_t inst;
        int    pick;
        inst = $random(seed);
        pick = {$random(seed)} % 12;
        case (pick)
            0: inst[6:0] = `DEC_OPC_OP_IMM;
            1: begin
                inst[6:0] = `DEC_OPC_OP;
                if (({$random(seed)} % 2) == 0) begin
                    inst[31:25] = 7'b0000000;
                end else begin
                    inst[31:25] = `DEC_F7_ALT;
                end
            end
            2: inst[6:0] = `DEC_OPC_LOAD;
            3: inst[6:0] = `DEC_OPC_STORE;
            4: inst[6:0] = `DEC_OPC_BRANCH;
            5: inst[6:0] = `DEC_OPC_JAL;
            6: inst[6:0] = `DEC_OPC_JALR;
            7: inst[6:0] = `DEC_OPC_LUI;
            8: inst[6:0] = `DEC_OPC_AUIPC;
            9: begin
                inst[6:0] = `DEC_OPC_SYSTEM;
                if (({$random(seed)} % 2) == 0) begin
                    inst = {`DEC_EBREAK_IMM, 5'd0, 3'b000, 5'd0, `DEC_OPC_SYSTEM};
                end
            end
            // fence, then a few rv64 and fp opcodes
            10: inst[6:0] = 7'b0001111;
            default: begin
                case ({$random(seed)} % 3)
                    0:       inst[6:0] = 7'b0011011;
                    1:       inst[6:0] = 7'b0111011;
                    default: inst[6:0] = 7'b1010011;
                endcase
            end
        endcase
        return inst;
    endfunction

    function automatic ctrl_word_t sample_outputs();
        ctrl_word_t w;
        w.rd          = rd_o;
        w.rs1         = rs1_o;
        w.rs2         = rs2_o;
        w.alu_op      = alu_op_o;
        w.src1_pc     = src1_pc_o;
        w.src2        = src2_o;
        w.jump        = jump_o;
        w.jump_pc_rel = jump_pc_rel_o;
        w.br_cmp      = br_cmp_o;
        w.write_gpr   = write_gpr_o;
        w.mem_to_reg  = mem_to_reg_o;
        w.write_mem   = write_mem_o;
        w.mem_size    = mem_size_o;
        w.halt        = halt_o;
        w.imm         = imm_o;
        return w;
    endfunction

    task automatic score_word(input ctrl_word_t got, input ctrl_word_t exp);
        check_val("rd", 128'(got.rd), 128'(exp.rd));
        check_val("rs1", 128'(got.rs1), 128'(exp.rs1));
        check_val("rs2", 128'(got.rs2), 128'(exp.rs2));
        check_val("alu_op", 128'(got.alu_op), 128'(exp.alu_op));
        check_val("src1_pc", 128'(got.src1_pc), 128'(exp.src1_pc));
        check_val("src2", 128'(got.src2), 128'(exp.src2));
        check_val("jump", 128'(got.jump), 128'(exp.jump));
        check_val("jump_pc_rel", 128'(got.jump_pc_rel), 128'(exp.jump_pc_rel));
        check_val("br_cmp", 128'(got.br_cmp), 128'(exp.br_cmp));
        check_val("write_gpr", 128'(got.write_gpr), 128'(exp.write_gpr));
        check_val("mem_to_reg", 128'(got.mem_to_reg), 128'(exp.mem_to_reg));
        check_val("write_mem", 128'(got.write_mem), 128'(exp.write_mem));
        check_val("mem_size", 128'(got.mem_size), 128'(exp.mem_size));
        check_val("halt", 128'(got.halt), 128'(exp.halt));
        check_val("imm", 128'(got.imm), 128'(exp.imm));
    endtask

    // upstream and downstream stimulus, 1 ns after the rising edge
    task automatic drive_inputs();
        inst_t next_inst;
        next_inst = gen_inst();
        while (n_sent < N_INST) begin
            @(posedge clk_i);
            #1;
            if (in_fire) begin
                n_sent++;
                next_inst = gen_inst();
            end
            burst = (n_sent >= BURST_FIRST) && (n_sent < BURST_LAST);
            if (n_sent >= N_INST) begin
                in_valid_i = 1'b0;
            end else if (!in_valid_i || in_fire) begin
                // valid stays up until taken
                inst_i     = next_inst;
                in_valid_i = burst || (({$random(seed)} % 3) != 0);
            end
            out_ready_i = burst || (({$random(seed)} % 3) != 0);
        end
        // drain the output register under random back-pressure
        while (out_valid_o) begin
            @(posedge clk_i);
            #1;
            out_ready_i = (({$random(seed)} % 3) != 0);
        end
    endtask

    // ==================================================================
    // monitor and scoreboard, sampled mid-cycle
    // ==================================================================
    always @(negedge clk_i) begin
        ctrl_word_t got;
        ctrl_word_t exp;
        if (mon_on) begin
            got = sample_outputs();
            check_val("in_ready", 128'(in_ready_o), 128'(!out_valid_o || out_ready_i));
            // in_fire still holds last cycle's accept here
            if (in_fire) begin
                check_val("out_valid after accept", 128'(out_valid_o), 128'(1'b1));
            end
            if (prev_stall) begin
                check_val("outputs held while stalled", 128'(got), 128'(prev_word));
            end
            if (burst) begin
                check_val("accept during burst", 128'(in_valid_i && in_ready_o), 128'(1'b1));
            end
            if (out_valid_o && out_ready_i) begin
                if (inst_q.size() == 0) begin
                    $display("error at %0t: output transfer with no instruction pending",
                             $time);
                    n_err++;
                end else begin
                    exp = decode_ref(inst_q.pop_front());
                    score_word(got, exp);
                    n_recv++;
                end
            end
            if (in_valid_i && in_ready_o) begin
                inst_q.push_back(inst_i);
            end
            in_fire    = in_valid_i && in_ready_o;
            prev_stall = out_valid_o && !out_ready_i;
            prev_word  = got;
        end
    end

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: not all instructions drained");
            $display("errors: %0d mismatches, %0d other, %0d of %0d instructions checked",
                     n_fail, n_err + 1, n_recv, N_INST);
            $display("test failed");
            $finish;
        end
    end

    // ==================================================================
    // main sequence
    // ==================================================================
    initial begin
        rst_n_i     = 1'b0;
        in_valid_i  = 1'b0;
        out_ready_i = 1'b0;
        inst_i      = '0;
        n_sent      = 0;
        n_recv      = 0;
        n_fail      = 0;
        n_err       = 0;
        in_fire     = 1'b0;
        prev_stall  = 1'b0;
        burst       = 1'b0;
        mon_on      = 1'b0;
        prev_word   = '0;

        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        #1;
        check_val("out_valid after reset", 128'(out_valid_o), 128'(1'b0));
        check_val("in_ready after reset", 128'(in_ready_o), 128'(1'b1));
        mon_on = 1'b1;

        drive_inputs();
        // a few idle cycles to catch extra outputs
        repeat (3) @(posedge clk_i);

        if (inst_q.size() != 0) begin
            $display("error: %0d instructions never came out", inst_q.size());
            n_err++;
        end
        if (n_recv != N_INST) begin
            $display("error: %0d instructions came out, %0d sent", n_recv, N_INST);
            n_err++;
        end
        $display("errors: %0d mismatches, %0d other, %0d of %0d instructions checked",
                 n_fail, n_err, n_recv, N_INST);
        if (n_fail == 0 && n_err == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    // upstream
    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    input  rv_dec_pkg::inst_t       inst_i,
    // downstream
    output logic                    out_valid_o,
    input  logic                    out_ready_i,
    output rv_dec_pkg::reg_addr_t   rd_o,
    output rv_dec_pkg::reg_addr_t   rs1_o,
    output rv_dec_pkg::reg_addr_t   rs2_o,
    output rv_dec_pkg::alu_op_t     alu_op_o,
    output logic                    src1_pc_o,
    output rv_dec_pkg::alu_src2_t   src2_o,
    output logic                    jump_o,
    output logic                    jump_pc_rel_o,
    output rv_dec_pkg::br_cmp_t     br_cmp_o,
    output logic                    write_gpr_o,
    output logic                    mem_to_reg_o,
    output logic                    write_mem_o,
    output rv_dec_pkg::mem_size_t   mem_size_o,
    output logic                    halt_o,
    output rv_dec_pkg::imm_t        imm_o
);

    import rv_dec_pkg::*;

    inst_class_t cls;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    funct3_t     funct3;
    funct7_t     funct7;
    alu_op_t     alu_op;
    logic        src1_pc;
    alu_src2_t   src2;
    logic        jump;
    logic        jump_pc_rel;
    br_cmp_t     br_cmp;
    logic        write_gpr;
    logic        mem_to_reg;
    logic        write_mem;
    mem_size_t   mem_size;
    logic        halt;
    imm_t        imm;
    logic        ebreak;
    logic        out_valid_q;
    logic        accept;

    // ==================================================================
    // combinational decode
    // ==================================================================
    inst_class_decode u_cls (
        .inst_i   (inst_i),
        .cls_o    (cls),
        .rd_o     (rd),
        .rs1_o    (rs1),
        .rs2_o    (rs2),
        .funct3_o (funct3),
        .funct7_o (funct7)
    );

    imm_gen u_imm (
        .inst_i   (inst_i),
        .cls_i    (cls),
        .imm_o    (imm),
        .ebreak_o (ebreak)
    );

    alu_ctrl_decode u_alu (
        .cls_i     (cls),
        .funct3_i  (funct3),
        .funct7_i  (funct7),
        .alu_op_o  (alu_op),
        .src1_pc_o (src1_pc),
        .src2_o    (src2)
    );

    flow_mem_decode u_flow (
        .cls_i         (cls),
        .funct3_i      (funct3),
        .ebreak_i      (ebreak),
        .jump_o        (jump),
        .jump_pc_rel_o (jump_pc_rel),
        .br_cmp_o      (br_cmp),
        .write_gpr_o   (write_gpr),
        .mem_to_reg_o  (mem_to_reg),
        .write_mem_o   (write_mem),
        .mem_size_o    (mem_size),
        .halt_o        (halt)
    );

    // ==================================================================
    // handshake and output register
    // ==================================================================

    // single slot: free when empty or being drained this cycle
    assign in_ready_o  = ~out_valid_q | out_ready_i;
    assign accept      = in_valid_i & in_ready_o;
    assign out_valid_o = out_valid_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_q <= 1'b0;
        end else if (in_ready_o) begin
            out_valid_q <= in_valid_i;
        end
    end

    // control word, held while stalled
    always_ff @(posedge clk_i) begin
        if (accept) begin
            rd_o          <= rd;
            rs1_o         <= rs1;
            rs2_o         <= rs2;
            alu_op_o      <= alu_op;
            src1_pc_o     <= src1_pc;
            src2_o        <= src2;
            jump_o        <= jump;
            jump_pc_rel_o <= jump_pc_rel;
            br_cmp_o      <= br_cmp;
            write_gpr_o   <= write_gpr;
            mem_to_reg_o  <= mem_to_reg;
            write_mem_o   <= write_mem;
            mem_size_o    <= mem_size;
            halt_o        <= halt;
            imm_o         <= imm;
        end
    end

endmodule

//--- design/imm_gen.sv
`timescale 1ns/1ps
`include "rv_dec_cfg.svh"

module imm_gen (
    input  rv_dec_pkg::inst_t       inst_i,
    input  rv_dec_pkg::inst_class_t cls_i,
    output rv_dec_pkg::imm_t        imm_o,
    output logic                    ebreak_o
);

    import rv_dec_pkg::*;

    imm_t imm_i_fmt;
    imm_t imm_s_fmt;
    imm_t imm_b_fmt;
    imm_t imm_u_fmt;
    imm_t imm_j_fmt;
    logic sel_i;
    logic sel_u;

    // format layouts, sign taken from bit 31
    assign imm_i_fmt = {{(`DEC_XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_s_fmt = {{(`DEC_XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b_fmt = {{(`DEC_XLEN-12){inst_i[31]}}, inst_i[7], inst_i[30:25],
                        inst_i[11:8], 1'b0};
    assign imm_u_fmt = {{(`DEC_XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};
    assign imm_j_fmt = {{(`DEC_XLEN-20){inst_i[31]}}, inst_i[19:12], inst_i[20],
                        inst_i[30:21], 1'b0};

    assign sel_i = cls_i[`DEC_CLS_OP_IMM] | cls_i[`DEC_CLS_LOAD]
                 | cls_i[`DEC_CLS_JALR] | cls_i[`DEC_CLS_SYSTEM];
    assign sel_u = cls_i[`DEC_CLS_LUI] | cls_i[`DEC_CLS_AUIPC];

    // class is one-hot, so and-or muxing is enough; op and unknown give zero
    assign imm_o = ({`DEC_XLEN{sel_i}} & imm_i_fmt)
                 | ({`DEC_XLEN{cls_i[`DEC_CLS_STORE]}} & imm_s_fmt)
                 | ({`DEC_XLEN{cls_i[`DEC_CLS_BRANCH]}} & imm_b_fmt)
                 | ({`DEC_XLEN{sel_u}} & imm_u_fmt)
                 | ({`DEC_XLEN{cls_i[`DEC_CLS_JAL]}} & imm_j_fmt);

    // ebreak lives in the i-immediate field of a system op
    assign ebreak_o = cls_i[`DEC_CLS_SYSTEM]
                    & (inst_i[14:12] == 3'b000)
                    & (inst_i[31:20] == `DEC_EBREAK_IMM);

endmodule

//--- design/flow_mem_decode.sv
`timescale 1ns/1ps
`include "rv_dec_cfg.svh"

module flow_mem_decode (
    input  rv_dec_pkg::inst_class_t cls_i,
    input  rv_dec_pkg::funct3_t     funct3_i,
    input  logic                    ebreak_i,
    output logic                    jump_o,
    output logic                    jump_pc_rel_o,
    output rv_dec_pkg::br_cmp_t     br_cmp_o,
    output logic                    write_gpr_o,
    output logic                    mem_to_reg_o,
    output logic                    write_mem_o,
    output rv_dec_pkg::mem_size_t   mem_size_o,
    output logic                    halt_o
);

    logic is_br;
    logic is_load;
    logic is_store;
    logic is_mem;

    assign is_br    = cls_i[`DEC_CLS_BRANCH];
    assign is_load  = cls_i[`DEC_CLS_LOAD];
    assign is_store = cls_i[`DEC_CLS_STORE];
    assign is_mem   = is_load | is_store;

    // ==================================================================
    // jumps and branches
    // ==================================================================

    // branches are treated as conditional jumps
    assign jump_o        = cls_i[`DEC_CLS_JAL] | cls_i[`DEC_CLS_JALR] | is_br;
    // jalr target is rs1 + imm, everything else pc + imm
    assign jump_pc_rel_o = cls_i[`DEC_CLS_JAL] | is_br;

    assign br_cmp_o[`DEC_CMP_EQ]  = is_br & (funct3_i == 3'b000);
    assign br_cmp_o[`DEC_CMP_NEQ] = is_br & (funct3_i == 3'b001);
    // signed and unsigned share the compare, alu op picks the flavour
    assign br_cmp_o[`DEC_CMP_LT]  = is_br & ((funct3_i == 3'b100) | (funct3_i == 3'b110));
    assign br_cmp_o[`DEC_CMP_GE]  = is_br & ((funct3_i == 3'b101) | (funct3_i == 3'b111));

    // ==================================================================
    // write-back
    // ==================================================================
    assign write_gpr_o  = ~(is_br | is_store | ebreak_i);
    assign mem_to_reg_o = is_load;

    // ==================================================================
    // memory access
    // ==================================================================
    assign write_mem_o = is_store;

    // signed sizes, loads and stores alike
    assign mem_size_o[`DEC_MEM_BYTE] = is_mem & (funct3_i == 3'b000);
    assign mem_size_o[`DEC_MEM_HALF] = is_mem & (funct3_i == 3'b001);
    assign mem_size_o[`DEC_MEM_WORD] = is_mem & (funct3_i == 3'b010);

    // zero-extending sizes, loads only
    assign mem_size_o[`DEC_MEM_BYTE_U] = is_load & (funct3_i == 3'b100);
    assign mem_size_o[`DEC_MEM_HALF_U] = is_load & (funct3_i == 3'b101);

    // ==================================================================
    // halt
    // ==================================================================
    assign halt_o = ebreak_i;

endmodule

//--- design/alu_ctrl_decode.sv
`timescale 1ns/1ps
`include "rv_dec_cfg.svh"

module alu_ctrl_decode (
    input  rv_dec_pkg::inst_class_t cls_i,
    input  rv_dec_pkg::funct3_t     funct3_i,
    input  rv_dec_pkg::funct7_t     funct7_i,
    output rv_dec_pkg::alu_op_t     alu_op_o,
    output logic                    src1_pc_o,
    output rv_dec_pkg::alu_src2_t   src2_o
);

    logic is_opi;
    logic is_op;
    logic is_br;
    logic is_arith;
    logic f7_zero;
    logic f7_alt;
    // bit 30 of the instruction
    logic alt_bit;

    assign is_opi   = cls_i[`DEC_CLS_OP_IMM];
    assign is_op    = cls_i[`DEC_CLS_OP];
    assign is_br    = cls_i[`DEC_CLS_BRANCH];
    assign is_arith = is_opi | is_op;
    assign f7_zero  = (funct7_i == '0);
    assign f7_alt   = (funct7_i == `DEC_F7_ALT);
    assign alt_bit  = funct7_i[5];

    // ==================================================================
    // alu operation
    // ==================================================================

    // address math for memory and jumps also uses the adder
    assign alu_op_o[`DEC_ALU_ADD] = (is_opi & (funct3_i == 3'b000))
                                  | (is_op & (funct3_i == 3'b000) & f7_zero)
                                  | cls_i[`DEC_CLS_AUIPC]
                                  | cls_i[`DEC_CLS_LOAD]
                                  | cls_i[`DEC_CLS_STORE]
                                  | cls_i[`DEC_CLS_JAL]
                                  | cls_i[`DEC_CLS_JALR];

    assign alu_op_o[`DEC_ALU_SUB] = is_op & (funct3_i == 3'b000) & f7_alt;

    // signed compare: slt, slti, beq, bne, blt, bge
    assign alu_op_o[`DEC_ALU_SLT] = (is_arith & (funct3_i == 3'b010))
                                  | (is_br & ((funct3_i == 3'b000) | (funct3_i == 3'b001)
                                            | (funct3_i == 3'b100) | (funct3_i == 3'b101)));

    // unsigned compare: sltu, sltiu, bltu, bgeu
    assign alu_op_o[`DEC_ALU_SLTU] = (is_arith & (funct3_i == 3'b011))
                                   | (is_br & ((funct3_i == 3'b110) | (funct3_i == 3'b111)));

    // logic ops
    assign alu_op_o[`DEC_ALU_OR]  = is_arith & (funct3_i == 3'b110);
    assign alu_op_o[`DEC_ALU_AND] = is_arith & (funct3_i == 3'b111);
    assign alu_op_o[`DEC_ALU_XOR] = is_arith & (funct3_i == 3'b100);

    // shifts, arithmetic right when bit 30 is set
    assign alu_op_o[`DEC_ALU_SLL] = is_arith & (funct3_i == 3'b001);
    assign alu_op_o[`DEC_ALU_SRL] = is_arith & (funct3_i == 3'b101) & ~alt_bit;
    assign alu_op_o[`DEC_ALU_SRA] = is_arith & (funct3_i == 3'b101) & alt_bit;

    // lui result is the immediate itself
    assign alu_op_o[`DEC_ALU_EXPLICIT] = cls_i[`DEC_CLS_LUI];

    // ==================================================================
    // operand selects
    // ==================================================================
    assign src1_pc_o = cls_i[`DEC_CLS_AUIPC] | cls_i[`DEC_CLS_JAL] | cls_i[`DEC_CLS_JALR];

    assign src2_o[`DEC_SRC2_RS2]  = is_op | is_br;
    assign src2_o[`DEC_SRC2_IMM]  = is_opi
                                  | cls_i[`DEC_CLS_AUIPC]
                                  | cls_i[`DEC_CLS_LUI]
                                  | cls_i[`DEC_CLS_LOAD]
                                  | cls_i[`DEC_CLS_STORE];
    // link address pc + 4
    assign src2_o[`DEC_SRC2_FOUR] = cls_i[`DEC_CLS_JAL] | cls_i[`DEC_CLS_JALR];

endmodule

//--- design/inst_class_decode.sv
`timescale 1ns/1ps
`include "rv_dec_cfg.svh"

module inst_class_decode (
    input  rv_dec_pkg::inst_t       inst_i,
    output rv_dec_pkg::inst_class_t cls_o,
    output rv_dec_pkg::reg_addr_t   rd_o,
    output rv_dec_pkg::reg_addr_t   rs1_o,
    output rv_dec_pkg::reg_addr_t   rs2_o,
    output rv_dec_pkg::funct3_t     funct3_o,
    output rv_dec_pkg::funct7_t     funct7_o
);

    logic [`DEC_OPC_W-1:0] opcode;

    // ==================================================================
    // field slicing
    // ==================================================================
    assign opcode   = inst_i[6:0];
    assign rd_o     = inst_i[11:7];
    assign funct3_o = inst_i[14:12];
    assign rs1_o    = inst_i[19:15];
    assign rs2_o    = inst_i[24:20];
    assign funct7_o = inst_i[31:25];

    // ==================================================================
    // class flags
    // ==================================================================

    // full 7-bit compare, so at most one bit is set
    // unknown opcodes leave the whole vector at zero

    // alu forms
    assign cls_o[`DEC_CLS_OP_IMM] = (opcode == `DEC_OPC_OP_IMM);
    assign cls_o[`DEC_CLS_OP]     = (opcode == `DEC_OPC_OP);

    // memory access
    assign cls_o[`DEC_CLS_LOAD]   = (opcode == `DEC_OPC_LOAD);
    assign cls_o[`DEC_CLS_STORE]  = (opcode == `DEC_OPC_STORE);

    // control flow
    assign cls_o[`DEC_CLS_BRANCH] = (opcode == `DEC_OPC_BRANCH);
    assign cls_o[`DEC_CLS_JAL]    = (opcode == `DEC_OPC_JAL);
    assign cls_o[`DEC_CLS_JALR]   = (opcode == `DEC_OPC_JALR);

    // upper immediate
    assign cls_o[`DEC_CLS_LUI]    = (opcode == `DEC_OPC_LUI);
    assign cls_o[`DEC_CLS_AUIPC]  = (opcode == `DEC_OPC_AUIPC);

    // only ebreak is acted on further down
    assign cls_o[`DEC_CLS_SYSTEM] = (opcode == `DEC_OPC_SYSTEM);

endmodule

//--- design/rv_dec_pkg.sv
`include "rv_dec_cfg.svh"

package rv_dec_pkg;

    // ==================================================================
    // instruction fields
    // ==================================================================

    // raw instruction word
    typedef logic [`DEC_INST_W-1:0] inst_t;

    // gpr index, rd / rs1 / rs2
    typedef logic [`DEC_REG_ADDR_W-1:0] reg_addr_t;

    // sign-extended immediate
    typedef logic [`DEC_XLEN-1:0] imm_t;

    typedef logic [`DEC_FUNCT3_W-1:0] funct3_t;
    typedef logic [`DEC_FUNCT7_W-1:0] funct7_t;

    // ==================================================================
    // one-hot control groups
    // ==================================================================

    // op_imm, op, load, store, branch, jal, jalr, lui, auipc, system
    typedef logic [`DEC_CLS_W-1:0] inst_class_t;

    // add .. sra plus explicit (operand 2 passed straight through)
    typedef logic [`DEC_ALU_W-1:0] alu_op_t;

    // rs2, imm, constant four
    typedef logic [`DEC_SRC2_W-1:0] alu_src2_t;

    // eq, neq, ge, lt
    typedef logic [`DEC_CMP_W-1:0] br_cmp_t;

    // byte, half, word, byte_u, half_u
    typedef logic [`DEC_MEM_W-1:0] mem_size_t;

endpackage

//--- design/rv_dec_cfg.svh
`ifndef RV_DEC_CFG_SVH
`define RV_DEC_CFG_SVH

// ======================================================================
// widths
// ======================================================================
`define DEC_INST_W      32
`define DEC_XLEN        32
`define DEC_REG_ADDR_W  5
`define DEC_OPC_W       7
`define DEC_FUNCT3_W    3
`define DEC_FUNCT7_W    7
`define DEC_CLS_W       10
`define DEC_ALU_W       11
`define DEC_SRC2_W      3
`define DEC_CMP_W       4
`define DEC_MEM_W       5

// ======================================================================
// major opcodes and special field values
// ======================================================================
`define DEC_OPC_LOAD    7'b0000011
`define DEC_OPC_STORE   7'b0100011
`define DEC_OPC_OP_IMM  7'b0010011
`define DEC_OPC_OP      7'b0110011
`define DEC_OPC_BRANCH  7'b1100011
`define DEC_OPC_JAL     7'b1101111
`define DEC_OPC_JALR    7'b1100111
`define DEC_OPC_LUI     7'b0110111
`define DEC_OPC_AUIPC   7'b0010111
`define DEC_OPC_SYSTEM  7'b1110011
// sub and sra
`define DEC_F7_ALT      7'b0100000
`define DEC_EBREAK_IMM  12'h001

// ======================================================================
// bit positions inside the one-hot control vectors
// ======================================================================
`define DEC_CLS_OP_IMM  0
`define DEC_CLS_OP      1
`define DEC_CLS_LOAD    2
`define DEC_CLS_STORE   3
`define DEC_CLS_BRANCH  4
`define DEC_CLS_JAL     5
`define DEC_CLS_JALR    6
`define DEC_CLS_LUI     7
`define DEC_CLS_AUIPC   8
`define DEC_CLS_SYSTEM  9

`define DEC_ALU_ADD       0
`define DEC_ALU_SUB       1
`define DEC_ALU_SLT       2
`define DEC_ALU_SLTU      3
`define DEC_ALU_OR        4
`define DEC_ALU_AND       5
`define DEC_ALU_XOR       6
`define DEC_ALU_SLL       7
`define DEC_ALU_SRL       8
`define DEC_ALU_SRA       9
`define DEC_ALU_EXPLICIT  10

`define DEC_SRC2_RS2    0
`define DEC_SRC2_IMM    1
`define DEC_SRC2_FOUR   2

`define DEC_CMP_EQ      0
`define DEC_CMP_NEQ     1
`define DEC_CMP_GE      2
`define DEC_CMP_LT      3

`define DEC_MEM_BYTE    0
`define DEC_MEM_HALF    1
`define DEC_MEM_WORD    2
`define DEC_MEM_BYTE_U  3
`define DEC_MEM_HALF_U  4

`endif
